//--- include/rp_defs.svh
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

//////////////////////////////////////////////////
// datapath widths

`define RP_SMP_W     14             // adc and dac sample width
`define RP_N_CHN     2              // analog channels
`define RP_PDM_CHN   4              // pdm outputs
`define RP_PDM_W     8              // pdm level width
`define RP_LED_W     8
`define RP_MID_CODE  14'h1FFF       // neg-slope code of a zero sample

//////////////////////////////////////////////////
// system bus

`define RP_SYS_W     32             // address and data width
`define RP_REG_MSB   22             // region field, 1 MB each
`define RP_REG_LSB   20
`define RP_N_REGION  8

// housekeeping byte offsets
`define RP_REG_ID       8'h00
`define RP_REG_LOOP     8'h04
`define RP_REG_LED      8'h08
`define RP_REG_LEVEL_A  8'h10
`define RP_REG_LEVEL_B  8'h14
`define RP_REG_PDM0     8'h20
`define RP_REG_PDM1     8'h24
`define RP_REG_PDM2     8'h28
`define RP_REG_PDM3     8'h2C

`define RP_HK_ID     32'hA1DA_0002  // board id, read only

`endif

//--- hdl/rp_pkg.sv
`include "rp_defs.svh"

package rp_pkg;

  // two's complement sample
  typedef logic signed [`RP_SMP_W-1:0] smp_t;

  // one request per cycle, enables are pulses
  typedef struct packed {
    logic [`RP_SYS_W-1:0] addr;
    logic [`RP_SYS_W-1:0] wdata;
    logic                 wen;
    logic                 ren;
  } sys_req_t;

  typedef struct packed {
    logic [`RP_SYS_W-1:0] rdata;
    logic                 ack;   // one cycle after request
    logic                 err;
  } sys_rsp_t;

  // settings from housekeeping into the datapath
  typedef struct packed {
    logic                                    loop;   // digital loopback
    smp_t [`RP_N_CHN-1:0]                    level;  // dc level per channel
    logic [`RP_PDM_CHN-1:0][`RP_PDM_W-1:0]   pdm;
  } hk_cfg_t;

  typedef enum logic [`RP_REG_MSB-`RP_REG_LSB:0] {
    REGION_HK = 3'd0,
    REGION_SCOPE,
    REGION_ASG,
    REGION_PID,
    REGION_AMS,
    REGION_SPARE5,
    REGION_SPARE6,
    REGION_SPARE7
  } sys_region_e;

  typedef enum logic [7:0] {
    REG_ID      = `RP_REG_ID,
    REG_LOOP    = `RP_REG_LOOP,
    REG_LED     = `RP_REG_LED,
    REG_LEVEL_A = `RP_REG_LEVEL_A,
    REG_LEVEL_B = `RP_REG_LEVEL_B,
    REG_PDM0    = `RP_REG_PDM0,
    REG_PDM1    = `RP_REG_PDM1,
    REG_PDM2    = `RP_REG_PDM2,
    REG_PDM3    = `RP_REG_PDM3
  } hk_reg_e;

endpackage

//--- hdl/sys_bus_decode.sv
`include "rp_defs.svh"

module sys_bus_decode (
  input  logic             adc_clk,
  input  logic             rst_i,
  input  rp_pkg::sys_req_t sys_req_i,  // from bus master
  output rp_pkg::sys_rsp_t sys_rsp_o,
  output rp_pkg::sys_req_t hk_req_o,   // region 0 only
  input  rp_pkg::sys_rsp_t hk_rsp_i
);

  rp_pkg::sys_region_e     region;
  rp_pkg::sys_region_e     region_q;     // region of the pending request
  logic [`RP_N_REGION-1:0] region_cs;    // one-hot chip select
  logic                    req;
  logic                    spare_ack_q;  // answer of unused regions

  assign region    = rp_pkg::sys_region_e'(sys_req_i.addr[`RP_REG_MSB:`RP_REG_LSB]);
  assign region_cs = {{(`RP_N_REGION-1){1'b0}}, 1'b1} << region;
  assign req       = sys_req_i.wen | sys_req_i.ren;

  // forward address and data, enables only for housekeeping
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & region_cs[rp_pkg::REGION_HK];
    hk_req_o.ren = sys_req_i.ren & region_cs[rp_pkg::REGION_HK];
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      region_q    <= rp_pkg::REGION_HK;
      spare_ack_q <= 1'b0;
    end
    else
    begin
      if (req)
        region_q <= region;                                  // hold until next request
      spare_ack_q <= req & (|region_cs[`RP_N_REGION-1:1]);   // empty regions ack at once
    end
  end

  //////////////////////////////////////////////////
  // response mux, selected by registered region

  always_comb
  begin
    if (region_q == rp_pkg::REGION_HK)
      sys_rsp_o = hk_rsp_i;
    else
    begin
      sys_rsp_o.rdata = '0;          // unused space reads zero
      sys_rsp_o.ack   = spare_ack_q;
      sys_rsp_o.err   = 1'b0;        // and never errors
    end
  end

endmodule

//--- hdl/hk_regs.sv
`include "rp_defs.svh"

module hk_regs (
  input  logic                 adc_clk,
  input  logic                 rst_i,
  input  rp_pkg::sys_req_t     req_i,
  output rp_pkg::sys_rsp_t     rsp_o,
  output rp_pkg::hk_cfg_t      cfg_o,
  output logic [`RP_LED_W-1:0] led_o
);

  rp_pkg::hk_reg_e      offs;
  logic                 page_ok;   // upper offset bits clear
  logic                 known;     // offset hits a register
  logic [`RP_SYS_W-1:0] rdata_d;
  logic [`RP_SYS_W-1:0] rdata_q;
  logic                 ack_q;
  logic                 err_q;
  rp_pkg::hk_cfg_t      cfg_q;
  logic [`RP_LED_W-1:0] led_q;

  assign offs    = rp_pkg::hk_reg_e'(req_i.addr[7:0]);
  assign page_ok = (req_i.addr[`RP_REG_LSB-1:8] == '0);

  //////////////////////////////////////////////////
  // writes, full word only

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      cfg_q <= '0;   // loopback off, levels zero
      led_q <= '0;
    end
    else if (req_i.wen && page_ok)
    begin
      case (offs)
        rp_pkg::REG_LOOP:    cfg_q.loop     <= req_i.wdata[0];
        rp_pkg::REG_LED:     led_q          <= req_i.wdata[`RP_LED_W-1:0];
        rp_pkg::REG_LEVEL_A: cfg_q.level[0] <= req_i.wdata[`RP_SMP_W-1:0];
        rp_pkg::REG_LEVEL_B: cfg_q.level[1] <= req_i.wdata[`RP_SMP_W-1:0];
        rp_pkg::REG_PDM0:    cfg_q.pdm[0]   <= req_i.wdata[`RP_PDM_W-1:0];
        rp_pkg::REG_PDM1:    cfg_q.pdm[1]   <= req_i.wdata[`RP_PDM_W-1:0];
        rp_pkg::REG_PDM2:    cfg_q.pdm[2]   <= req_i.wdata[`RP_PDM_W-1:0];
        rp_pkg::REG_PDM3:    cfg_q.pdm[3]   <= req_i.wdata[`RP_PDM_W-1:0];
        default: ;                       // id is read only
      endcase
    end
  end

  //////////////////////////////////////////////////
  // read mux and offset check

  always_comb
  begin
    rdata_d = '0;
    known   = page_ok;
    case (offs)
      rp_pkg::REG_ID:      rdata_d = `RP_HK_ID;
      rp_pkg::REG_LOOP:    rdata_d[0] = cfg_q.loop;
      rp_pkg::REG_LED:     rdata_d[`RP_LED_W-1:0] = led_q;
      rp_pkg::REG_LEVEL_A: rdata_d = `RP_SYS_W'(cfg_q.level[0]);   // sign extended
      rp_pkg::REG_LEVEL_B: rdata_d = `RP_SYS_W'(cfg_q.level[1]);
      rp_pkg::REG_PDM0:    rdata_d[`RP_PDM_W-1:0] = cfg_q.pdm[0];
      rp_pkg::REG_PDM1:    rdata_d[`RP_PDM_W-1:0] = cfg_q.pdm[1];
      rp_pkg::REG_PDM2:    rdata_d[`RP_PDM_W-1:0] = cfg_q.pdm[2];
      rp_pkg::REG_PDM3:    rdata_d[`RP_PDM_W-1:0] = cfg_q.pdm[3];
      default:             known = 1'b0;
    endcase
  end

  // ack one cycle after any request
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      err_q <= (req_i.wen | req_i.ren) & ~known;   // bad offset
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rdata_q <= (req_i.ren && known) ? rdata_d : '0;
  end

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};
  assign cfg_o = cfg_q;
  assign led_o = led_q;

endmodule

//--- hdl/adc_frontend.sv
`include "rp_defs.svh"

module adc_frontend (
  input  logic                                adc_clk,
  input  logic                                rst_i,
  input  logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] adc_raw_i,  // unsigned, neg slope
  input  logic                                loop_i,
  input  rp_pkg::smp_t [`RP_N_CHN-1:0]        dac_smp_i,  // loopback source
  output rp_pkg::smp_t [`RP_N_CHN-1:0]        adc_smp_o
);

  logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] raw_q;   // input capture

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      raw_q <= {`RP_N_CHN{`RP_MID_CODE}};   // mid code, zero sample
    else
      raw_q <= adc_raw_i;
  end

  // keep msb, invert the rest, then pick loopback
  always_comb
  begin
    for (int i = 0; i < `RP_N_CHN; i++)
    begin
      if (loop_i)
        adc_smp_o[i] = dac_smp_i[i];
      else
        adc_smp_o[i] = {raw_q[i][`RP_SMP_W-1], ~raw_q[i][`RP_SMP_W-2:0]};
    end
  end

endmodule

//--- hdl/analog_chan.sv
`include "rp_defs.svh"

module analog_chan (
  input  logic         adc_clk,
  input  logic         rst_i,
  input  rp_pkg::smp_t adc_smp_i,
  input  rp_pkg::smp_t level_i,    // programmable dc level
  output rp_pkg::smp_t dac_smp_o
);

  logic signed [`RP_SMP_W:0] sum;   // one guard bit
  rp_pkg::smp_t              sat;
  rp_pkg::smp_t              smp_q;

  assign sum = adc_smp_i + level_i;

  // guard and msb differ -> overflow, clamp to the rail of the sign
  always_comb
  begin
    if (sum[`RP_SMP_W] != sum[`RP_SMP_W-1])
      sat = {sum[`RP_SMP_W], {(`RP_SMP_W-1){~sum[`RP_SMP_W]}}};
    else
      sat = sum[`RP_SMP_W-1:0];
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      smp_q <= '0;
    else
      smp_q <= sat;
  end

  assign dac_smp_o = smp_q;

endmodule

//--- hdl/dac_backend.sv
`include "rp_defs.svh"

module dac_backend (
  input  logic                                adc_clk,
  input  logic                                rst_i,
  input  rp_pkg::smp_t [`RP_N_CHN-1:0]        dac_smp_i,
  output logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] dac_dat_o   // unsigned, neg slope
);

  logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] code;

  // signed to neg-slope code, same mapping as the adc side
  always_comb
  begin
    for (int i = 0; i < `RP_N_CHN; i++)
    begin
      code[i] = {dac_smp_i[i][`RP_SMP_W-1], ~dac_smp_i[i][`RP_SMP_W-2:0]};
    end
  end

  //////////////////////////////////////////////////
  // output registers, one port per channel

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      dac_dat_o <= {`RP_N_CHN{`RP_MID_CODE}};   // zero output
    else
      dac_dat_o <= code;
  end

endmodule

//--- hdl/pdm_gen.sv
`include "rp_defs.svh"

module pdm_gen (
  input  logic                                  adc_clk,
  input  logic                                  rst_i,
  input  logic [`RP_PDM_CHN-1:0][`RP_PDM_W-1:0] level_i,
  output logic [`RP_PDM_CHN-1:0]                pdm_o
);

  logic [`RP_PDM_CHN-1:0][`RP_PDM_W-1:0] acc_q;
  logic [`RP_PDM_CHN-1:0][`RP_PDM_W:0]   acc_sum;   // carry on top
  logic [`RP_PDM_CHN-1:0]                pdm_q;

  // first order modulator, carry rate = level / 256
  always_comb
  begin
    for (int i = 0; i < `RP_PDM_CHN; i++)
    begin
      acc_sum[i] = {1'b0, acc_q[i]} + {1'b0, level_i[i]};
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      acc_q <= '0;
      pdm_q <= '0;
    end
    else
    begin
      for (int i = 0; i < `RP_PDM_CHN; i++)
      begin
        acc_q[i] <= acc_sum[i][`RP_PDM_W-1:0];   // wraps mod 256
        pdm_q[i] <= acc_sum[i][`RP_PDM_W];       // carry out
      end
    end
  end

  assign pdm_o = pdm_q;

endmodule

//--- hdl/rp_core.sv
`include "rp_defs.svh"

module rp_core (
  input  logic                                adc_clk,
  input  logic                                rst_i,
  input  logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] adc_dat_i,
  output logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] dac_dat_o,
  output logic [`RP_PDM_CHN-1:0]              dac_pwm_o,   // 1-bit pdm dacs
  output logic [`RP_LED_W-1:0]                led_o,
  input  rp_pkg::sys_req_t                    sys_req_i,
  output rp_pkg::sys_rsp_t                    sys_rsp_o
);

  rp_pkg::sys_req_t             hk_req;
  rp_pkg::sys_rsp_t             hk_rsp;
  rp_pkg::hk_cfg_t              cfg;       // loopback, levels, pdm
  rp_pkg::smp_t [`RP_N_CHN-1:0] adc_smp;   // two's complement in
  rp_pkg::smp_t [`RP_N_CHN-1:0] dac_smp;   // saturated out

  //////////////////////////////////////////////////
  // system bus and housekeeping

  sys_bus_decode u_bus_decode (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp)
  );

  hk_regs u_hk (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .req_i   (hk_req),
    .rsp_o   (hk_rsp),
    .cfg_o   (cfg),
    .led_o   (led_o)
  );

  //////////////////////////////////////////////////
  // analog path, adc -> channels -> dac

  adc_frontend u_adc (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .adc_raw_i (adc_dat_i),
    .loop_i    (cfg.loop),
    .dac_smp_i (dac_smp),   // loopback
    .adc_smp_o (adc_smp)
  );

  for (genvar i = 0; i < `RP_N_CHN; i++)
  begin : g_chan
    analog_chan u_chan (
      .adc_clk   (adc_clk),
      .rst_i     (rst_i),
      .adc_smp_i (adc_smp[i]),
      .level_i   (cfg.level[i]),
      .dac_smp_o (dac_smp[i])
    );
  end

  dac_backend u_dac (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .dac_smp_i (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

  // slow analog outputs
  pdm_gen u_pdm (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .level_i (cfg.pdm),
    .pdm_o   (dac_pwm_o)
  );

endmodule

//--- test/rp_core_props.sv
module rp_core_props (
  input logic             adc_clk,
  input logic             rst_i,
  input rp_pkg::sys_req_t req_i,
  input rp_pkg::sys_rsp_t rsp_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic req;
  int   fail_cnt = 0;   // failed assertions so far

  assign req = req_i.wen | req_i.ren;

  //////////////////////////////////////////////////
  // bus handshake with a fixed ack latency of one

  ack_latency: assert property (@(posedge adc_clk) disable iff (rst_i) req |=> rsp_i.ack)
  else
  begin
    $error("no ack in the cycle after a request");
    fail_cnt++;
  end

  ack_needs_req: assert property (@(posedge adc_clk) disable iff (rst_i)
    rsp_i.ack |-> $past(req))
  else
  begin
    $error("ack without a request in the cycle before");
    fail_cnt++;
  end

  err_with_ack: assert property (@(posedge adc_clk) disable iff (rst_i) rsp_i.err |-> rsp_i.ack)
  else
  begin
    $error("err raised outside an ack cycle");
    fail_cnt++;
  end

  // sync reset clears ack on the next edge
  ack_in_reset: assert property (@(posedge adc_clk) rst_i |=> !rsp_i.ack)
  else
  begin
    $error("ack high while reset is applied");
    fail_cnt++;
  end

endmodule

bind sys_bus_decode rp_core_props u_props (
  .adc_clk (adc_clk),
  .rst_i   (rst_i),
  .req_i   (sys_req_i),
  .rsp_i   (sys_rsp_o)
);

//--- test/rp_core_tb.sv
`include "rp_defs.svh"

module rp_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF   = 50;    // 100 ns period
  localparam int RST_CYC    = 10;
  localparam int ACK_WAIT   = 8;     // cycles before a missing ack counts as lost
  localparam int N_RAND     = 200;
  localparam int N_SAT      = 40;
  localparam int LOOP_WAIT  = 100;
  localparam int PDM_WIN    = 256;
  // two cycles per bus access plus the stimulus of each test
  localparam int RUN_CYC    = RST_CYC + 2 * 36 + (N_RAND + 8) + 2 * (N_SAT + 8)
                              + (LOOP_WAIT + 30) + (PDM_WIN + 12);
  localparam int MARGIN_CYC = 200;

  logic                                adc_clk = 1'b0;
  logic                                rst;
  logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] adc_dat;
  logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] dac_dat;
  logic [`RP_PDM_CHN-1:0]              pwm;
  logic [`RP_LED_W-1:0]                led;
  rp_pkg::sys_req_t                    sys_req;
  rp_pkg::sys_rsp_t                    sys_rsp;

  integer               seed = 29;
  int                   err_cnt = 0;
  int                   chk_cnt = 0;
  int                   prop_fails;
  logic [`RP_SYS_W-1:0] rd_data;   // last bus answer
  logic                 rd_err;
  int                   lvl [`RP_N_CHN];   // model of the channel levels
  logic                 chk_en;            // pipeline checker on while loopback is off
  int                   wait_cyc;
  logic [`RP_SMP_W-1:0] rail_hi;
  logic [`RP_SMP_W-1:0] rail_lo;
  int                   hi_cnt [`RP_PDM_CHN];
  int                   pdm_lvl [`RP_PDM_CHN] = '{0, 1, 128, 255};
  logic [`RP_SMP_W-1:0] ext_code [4] = '{14'h0000, 14'h3FFF, 14'h1FFF, 14'h2000};

  // 3-deep input history for the checker
  logic [`RP_N_CHN-1:0][`RP_SMP_W-1:0] raw_hist [3];
  int                                  lvl_hist [3][`RP_N_CHN];
  logic                                vld_hist [3];
  logic [`RP_SMP_W-1:0]                dac_exp;

  rp_core u_dut (
    .adc_clk   (adc_clk),
    .rst_i     (rst),
    .adc_dat_i (adc_dat),
    .dac_dat_o (dac_dat),
    .dac_pwm_o (pwm),
    .led_o     (led),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp)
  );

  always #(CLK_HALF) adc_clk = ~adc_clk;

  // raw code to signed, add level, clamp, back to dac code
  function automatic logic [`RP_SMP_W-1:0] dac_code_ref(input logic [`RP_SMP_W-1:0] raw,
                                                        input int level);
    int smp;
    int sum;
    smp = 8191 - int'(raw);   // 0x1FFF is zero and code 0 full positive
    sum = smp + level;
    if (sum > 8191)
      sum = 8191;
    else if (sum < -8192)
      sum = -8192;
    return `RP_SMP_W'(8191 - sum);
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    err_cnt++;
  endtask

  task automatic report_problem(input string msg);
    $display("%0t: %s", $time, msg);
    err_cnt++;
  endtask

  //////////////////////////////////////////////////
  // bus master issues one request and waits for ack

  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
    int n;
    n = 0;
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = ~wr;
    @(negedge adc_clk);
    sys_req.wen = 1'b0;   // single cycle pulse
    sys_req.ren = 1'b0;
    while (!sys_rsp.ack && n < ACK_WAIT)
    begin
      @(negedge adc_clk);
      n++;
    end
    assert (sys_rsp.ack)
      else report_problem($sformatf("request to address %h never got an ack", addr));
    rd_data = sys_rsp.rdata;
    rd_err  = sys_rsp.err;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bus_access(1'b1, addr, data);
    assert (!rd_err)
      else report_problem($sformatf("write to address %h answered with err", addr));
  endtask

  task automatic bus_read(input logic [31:0] addr);
    bus_access(1'b0, addr, '0);
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp, input logic err);
    bus_read(addr);
    assert (rd_data == exp && rd_err == err)
      else report_mismatch($sformatf("read at %h (err %b, want %b)", addr, rd_err, err),
                           rd_data, exp);
  endtask

  task automatic write_readback(input logic [31:0] addr, input logic [31:0] data);
    bus_write(addr, data);
    read_expect(addr, data, 1'b0);
  endtask

  task automatic set_levels(input int a, input int b);
    lvl[0] = a;
    lvl[1] = b;
    bus_write(`RP_REG_LEVEL_A, 32'(a));
    bus_write(`RP_REG_LEVEL_B, 32'(b));
  endtask

  // drive n codes per channel with the checker on and drain the pipeline
  task automatic run_codes(input int n, input logic extreme);
    chk_en = 1'b1;
    for (int i = 0; i < n; i++)
    begin
      for (int c = 0; c < `RP_N_CHN; c++)
      begin
        if (extreme)
          adc_dat[c] = ext_code[(i + c) % 4];   // each channel walks all four
        else
          adc_dat[c] = `RP_SMP_W'($random(seed));
      end
      @(negedge adc_clk);
    end
    repeat (3) @(negedge adc_clk);   // pipeline depth
    chk_en = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // history shifts on the rising edge, compare on the falling one

  always @(posedge adc_clk)
  begin
    for (int i = 2; i > 0; i--)
    begin
      raw_hist[i] <= raw_hist[i-1];
      vld_hist[i] <= vld_hist[i-1];
      for (int c = 0; c < `RP_N_CHN; c++)
        lvl_hist[i][c] <= lvl_hist[i-1][c];
    end
    raw_hist[0] <= adc_dat;
    vld_hist[0] <= chk_en & ~rst;
    for (int c = 0; c < `RP_N_CHN; c++)
      lvl_hist[0][c] <= lvl[c];
  end

  always @(negedge adc_clk)
  begin
    if (vld_hist[2])
    begin
      for (int c = 0; c < `RP_N_CHN; c++)
      begin
        dac_exp = dac_code_ref(raw_hist[2][c], lvl_hist[2][c]);
        chk_cnt++;
        assert (dac_dat[c] == dac_exp)
          else report_mismatch($sformatf("dac code ch%0d", c), 32'(dac_dat[c]), 32'(dac_exp));
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  initial
  begin
    rst     = 1'b1;
    sys_req = '0;
    adc_dat = {`RP_N_CHN{`RP_MID_CODE}};
    chk_en  = 1'b0;
    lvl[0]  = 0;
    lvl[1]  = 0;
    rail_hi = dac_code_ref(`RP_MID_CODE, 8191);    // code of +8191
    rail_lo = dac_code_ref(`RP_MID_CODE, -8192);   // code of -8192
    repeat (RST_CYC) @(negedge adc_clk);

    // state at the end of reset
    assert (dac_dat[0] == 14'h1FFF && dac_dat[1] == 14'h1FFF)
      else report_mismatch("dac codes in reset", 32'(dac_dat), 32'({14'h1FFF, 14'h1FFF}));
    assert (pwm == '0)
      else report_mismatch("pdm outputs in reset", 32'(pwm), 32'h0);
    assert (led == '0)
      else report_mismatch("leds in reset", 32'(led), 32'h0);
    assert (!sys_rsp.ack)
      else report_mismatch("ack in reset", 32'(sys_rsp.ack), 32'h0);
    rst = 1'b0;

    // register map
    read_expect(`RP_REG_ID, `RP_HK_ID, 1'b0);
    write_readback(`RP_REG_LOOP, 32'h1);
    write_readback(`RP_REG_LOOP, 32'h0);
    write_readback(`RP_REG_LED, 32'hA5);
    assert (led == 8'hA5)
      else report_mismatch("led_o", 32'(led), 32'hA5);
    write_readback(`RP_REG_LEVEL_A, 32'(1000));
    write_readback(`RP_REG_LEVEL_B, 32'(-1000));   // sign extended on read
    for (int k = 0; k < `RP_PDM_CHN; k++)
      write_readback(`RP_REG_PDM0 + 4 * k, 32'h11 * (k + 3));
    read_expect(32'h40, 32'h0, 1'b1);               // hole in the map
    for (int r = 1; r < `RP_N_REGION; r++)
    begin
      bus_write((r << `RP_REG_LSB) | `RP_REG_LOOP, 32'hFFFF_FFFF);
      read_expect((r << `RP_REG_LSB) | `RP_REG_ID, 32'h0, 1'b0);
    end
    read_expect(`RP_REG_LOOP, 32'h0, 1'b0);         // other regions never reach housekeeping

    // passthrough with random levels
    set_levels($random(seed) % 1001, $random(seed) % 1001);
    run_codes(N_RAND, 1'b0);

    // saturation against both rails in turn
    set_levels(8191, -8191);
    run_codes(N_SAT, 1'b1);
    set_levels(-8191, 8191);
    run_codes(N_SAT, 1'b1);

    // loopback ramps each channel into its rail
    adc_dat = {`RP_N_CHN{`RP_MID_CODE}};
    set_levels(100, -100);
    bus_write(`RP_REG_LOOP, 32'h1);
    wait_cyc = 0;
    while (!(dac_dat[0] == rail_hi && dac_dat[1] == rail_lo) && wait_cyc < LOOP_WAIT)
    begin
      @(negedge adc_clk);
      wait_cyc++;
    end
    assert (dac_dat[0] == rail_hi && dac_dat[1] == rail_lo)
      else report_problem("loopback did not reach both rails within 100 cycles");
    repeat (20)
    begin
      @(negedge adc_clk);
      assert (dac_dat[0] == rail_hi && dac_dat[1] == rail_lo)
        else report_mismatch("loopback rails", 32'(dac_dat), 32'({rail_lo, rail_hi}));
    end
    bus_write(`RP_REG_LOOP, 32'h0);

    // pdm duty over one full accumulator period
    for (int k = 0; k < `RP_PDM_CHN; k++)
    begin
      bus_write(`RP_REG_PDM0 + 4 * k, 32'(pdm_lvl[k]));
      hi_cnt[k] = 0;
    end
    repeat (2) @(negedge adc_clk);   // let the new levels reach the outputs
    repeat (PDM_WIN)
    begin
      @(negedge adc_clk);
      for (int k = 0; k < `RP_PDM_CHN; k++)
        hi_cnt[k] += int'(pwm[k]);
    end
    for (int k = 0; k < `RP_PDM_CHN; k++)
      assert (hi_cnt[k] == pdm_lvl[k])
        else report_mismatch($sformatf("pdm%0d high count", k), hi_cnt[k], pdm_lvl[k]);

    prop_fails = u_dut.u_bus_decode.u_props.fail_cnt;
    $display("dac checks %0d, errors %0d, bus assertion failures %0d",
             chk_cnt, err_cnt, prop_fails);
    if (err_cnt == 0 && prop_fails == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #((RUN_CYC + MARGIN_CYC) * 2 * CLK_HALF);
    $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYC + MARGIN_CYC);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
hdl/rp_pkg.sv
hdl/sys_bus_decode.sv
hdl/hk_regs.sv
hdl/adc_frontend.sv
hdl/analog_chan.sv
hdl/dac_backend.sv
hdl/pdm_gen.sv
hdl/rp_core.sv
test/rp_core_props.sv
test/rp_core_tb.sv

//--- Makefile
SIM        = verilator
TOP        = rp_core_tb
FILELIST   = verilog.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
PASS_MSG   = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# exit status comes from grep, so a missing pass line fails the target
sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
